/* rtl/fdc_cmd_pkg.sv */
// fdc command package with opcode classes, busy states, register addresses and status bits
package fdc_cmd_pkg;

  // decoded command class, taken from the upper nibble of the command byte
  typedef enum logic [3:0] {
    op_restore,      // 0000
    op_seek,         // 0001
    op_step,         // 001u
    op_step_in,      // 010u
    op_step_out,     // 011u
    op_read_sector,  // 100x
    op_write_sector, // 101x
    op_read_address, // 1100
    op_read_track,   // 1110
    op_write_track,  // 1111
    op_force_int     // 1101
  } fdc_op_e;

  // busy state of the controller
  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_irq      = 2'd1, // one cycle before irq goes high
    st_int_wait = 2'd2, // internal delay running
    st_io_wait  = 2'd3  // waiting for the io controller
  } fdc_busy_e;

  // cpu visible register map
  typedef enum logic [1:0] {
    reg_cmd_status = 2'd0,
    reg_track      = 2'd1,
    reg_sector     = 2'd2,
    reg_data       = 2'd3
  } fdc_reg_e;

  // bit positions in the status register
  localparam int stat_motor_on     = 7;
  localparam int stat_write_protect = 6;
  localparam int stat_spin_up_done = 5; // type I only
  localparam int stat_track_zero   = 2; // type I only
  localparam int stat_drq_or_index = 1; // index for type I, drq otherwise
  localparam int stat_busy         = 0;

  // bits 4 and 3 would be seek error and crc error on a real part
  // they always read 0 here

endpackage

/* rtl/fdc_timing_pkg.sv */
// fdc timing package with the scaled delays for stepping, motor and index
package fdc_timing_pkg;

  // all counters in the design use this width
  localparam int delay_width = 32;

  // internal wait for restore and for a seek that really moves
  localparam logic [delay_width-1:0] seek_delay = 32'd200;

  // internal wait for step, step-in and step-out
  localparam logic [delay_width-1:0] step_delay = 32'd20;

  // motor keeps running this long after a command
  localparam logic [delay_width-1:0] motor_run_time = 32'd160;

  // start from standstill, counter above motor_run_time means spinning up
  localparam logic [delay_width-1:0] motor_spinup_time = 32'd240;

  // index counter reload value, one full turn is index_period+1 cycles
  localparam logic [delay_width-1:0] index_period = 32'd16;

  // real hardware figures for reference
  // seek about 25 ms, step about 2.5 ms at 8 MHz
  // motor 2 s run, 1 s extra spin up, 5 turns per second
  // simulation uses the short values above

endpackage

/* rtl/fdc_reg_if.sv */
// register access channel from the bus slave to the fdc controller
`timescale 1ns/1ps

interface fdc_reg_if;

  logic                   acc;   // single cycle access strobe
  logic                   we;    // write when high, read otherwise
  fdc_cmd_pkg::fdc_reg_e  addr;  // register select
  logic [7:0]             wdata; // write data
  logic [7:0]             rdata; // read data, combinational from addr

  // bus side drives the request
  modport slave (
    output acc,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  // controller side answers with the addressed register
  modport ctrl (
    input  acc,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* rtl/fdc_wb_slave.sv */
// wishbone classic slave, one register access strobe per bus cycle
`timescale 1ns/1ps

module fdc_wb_slave (
  input  logic       clk,
  input  logic       motor_start_or_force,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [1:0] wb_adr,
  input  logic [7:0] wb_dat_i,
  output logic [7:0] wb_dat_o,
  output logic       wb_ack,
  fdc_reg_if.slave   regs
);

  // two step sequencer, access cycle then ack cycle
  typedef enum logic [1:0] {
    wb_idle,   // waiting for cyc and stb
    wb_access, // acc high toward the controller
    wb_reply   // ack high toward the master
  } wb_state_e;

  wb_state_e             state;
  logic                  req;
  logic                  we_q;
  fdc_cmd_pkg::fdc_reg_e addr_q;
  logic [7:0]            wdata_q;

  assign req = wb_cyc && wb_stb;

  always_ff @(posedge clk or posedge motor_start_or_force) begin
    if (motor_start_or_force) begin
      state <= wb_idle;
    end else begin
      case (state)
        wb_idle:   if (req) state <= wb_access;
        wb_access: state <= wb_reply;
        wb_reply:  state <= wb_idle; // stb may still be high here, ignored
        default:   state <= wb_idle;
      endcase
    end
  end

  // request fields latched when the cycle is accepted
  always_ff @(posedge clk) begin
    if (state == wb_idle && req) begin
      we_q    <= wb_we;
      addr_q  <= fdc_cmd_pkg::fdc_reg_e'(wb_adr);
      wdata_q <= wb_dat_i;
    end
  end

  // read data taken on the acc cycle, so before any write lands
  always_ff @(posedge clk) begin
    if (state == wb_access) begin
      wb_dat_o <= regs.rdata;
    end
  end

  assign regs.acc   = (state == wb_access);
  assign regs.we    = we_q;
  assign regs.addr  = addr_q;
  assign regs.wdata = wdata_q;
  assign wb_ack     = (state == wb_reply); // lasts exactly one cycle

endmodule

/* rtl/fdc_motor.sv */
// floppy motor model with spin up countdown and index pulse generation
`timescale 1ns/1ps

module fdc_motor (
  input  logic clk,
  input  logic motor_start_or_force,
  input  logic motor_start,   // type I or II command issued
  input  logic force_spinup,  // force interrupt issued
  output logic motor_on,
  output logic spin_up_done,
  output logic index_pulse
);

  logic [fdc_timing_pkg::delay_width-1:0] motor_cnt;
  logic [fdc_timing_pkg::delay_width-1:0] index_cnt;
  logic                                   motor_load;

  assign motor_load = motor_start || force_spinup;

  // motor on timer
  // a running motor just gets the run time again
  // a stopped motor, or any force interrupt, goes through spin up first
  always_ff @(posedge clk or posedge motor_start_or_force) begin
    if (motor_start_or_force) begin
      motor_cnt <= '0;
    end else if (motor_load) begin
      motor_cnt <= (motor_on && !force_spinup) ? fdc_timing_pkg::motor_run_time
                                               : fdc_timing_pkg::motor_spinup_time;
    end else if (motor_cnt != '0) begin
      motor_cnt <= motor_cnt - 1'b1; // let the motor run down
    end
  end

  assign motor_on     = (motor_cnt != '0);
  assign spin_up_done = motor_on && (motor_cnt <= fdc_timing_pkg::motor_run_time);

  // index counter, parked at zero while the disk stands still
  always_ff @(posedge clk or posedge motor_start_or_force) begin
    if (motor_start_or_force) begin
      index_cnt <= '0;
    end else if (!motor_on) begin
      index_cnt <= '0;
    end else if (index_cnt != '0) begin
      index_cnt <= index_cnt - 1'b1;
    end else begin
      index_cnt <= fdc_timing_pkg::index_period; // next revolution
    end
  end

  // high only at the top count, one cycle per turn
  assign index_pulse = (index_cnt > fdc_timing_pkg::index_period - 32'd1);

endmodule

/* rtl/fdc_controller.sv */
// fdc controller with register file, command decode, busy state machine and irq
`timescale 1ns/1ps

module fdc_controller (
  input  logic       clk,
  input  logic       motor_start_or_force,
  fdc_reg_if.ctrl    regs,
  input  logic       wr_prot,       // write protect of selected drive
  input  logic [1:0] drv_sel,
  input  logic       drv_side,
  input  logic       dma_ack,       // io controller finished the transfer
  input  logic [2:0] status_sel,
  output logic [7:0] status_byte,
  output logic       irq,
  output logic       motor_start,
  output logic       force_spinup,
  input  logic       motor_on,
  input  logic       spin_up_done,
  input  logic       index_pulse
);

  logic [7:0]                             cmd;    // last command, write only
  logic [7:0]                             track;
  logic [7:0]                             sector;
  logic [7:0]                             data;
  logic                                   step_dir; // 1 steps in
  fdc_cmd_pkg::fdc_busy_e                 state;
  logic [fdc_timing_pkg::delay_width-1:0] delay_cnt;
  fdc_cmd_pkg::fdc_op_e                   wr_op;  // command being written
  logic                                   cur_type1;
  logic                                   wr_starts_motor;
  logic                                   io_wait;
  logic                                   busy;
  logic [1:0]                             drv_sel_excl;
  logic [7:0]                             status;

  // command class from the upper nibble
  function automatic fdc_cmd_pkg::fdc_op_e decode_op(input logic [7:0] c);
    fdc_cmd_pkg::fdc_op_e op;
    op = fdc_cmd_pkg::op_restore;
    casez (c[7:4])
      4'b0000: op = fdc_cmd_pkg::op_restore;
      4'b0001: op = fdc_cmd_pkg::op_seek;
      4'b001?: op = fdc_cmd_pkg::op_step;
      4'b010?: op = fdc_cmd_pkg::op_step_in;
      4'b011?: op = fdc_cmd_pkg::op_step_out;
      4'b100?: op = fdc_cmd_pkg::op_read_sector;
      4'b101?: op = fdc_cmd_pkg::op_write_sector;
      4'b1100: op = fdc_cmd_pkg::op_read_address;
      4'b1101: op = fdc_cmd_pkg::op_force_int;
      4'b1110: op = fdc_cmd_pkg::op_read_track;
      4'b1111: op = fdc_cmd_pkg::op_write_track;
      default: op = fdc_cmd_pkg::op_restore;
    endcase
    return op;
  endfunction

  assign wr_op     = decode_op(regs.wdata);
  assign cur_type1 = (cmd[7] == 1'b0);
  assign io_wait   = (state == fdc_cmd_pkg::st_io_wait);
  assign busy      = io_wait || (state == fdc_cmd_pkg::st_int_wait);

  // type I and type II spin the motor, type III does not
  assign wr_starts_motor = (regs.wdata[7] == 1'b0) || (wr_op == fdc_cmd_pkg::op_read_sector) ||
                           (wr_op == fdc_cmd_pkg::op_write_sector);

  always_ff @(posedge clk or posedge motor_start_or_force) begin
    if (motor_start_or_force) begin
      cmd          <= '0;
      track        <= '0;
      sector       <= '0;
      data         <= '0;
      step_dir     <= 1'b0;
      state        <= fdc_cmd_pkg::st_idle;
      delay_cnt    <= '0;
      irq          <= 1'b0;
      motor_start  <= 1'b0;
      force_spinup <= 1'b0;
    end else begin
      motor_start  <= 1'b0;
      force_spinup <= 1'b0;
      if (dma_ack && io_wait) state <= fdc_cmd_pkg::st_irq; // transfer done
      if (state == fdc_cmd_pkg::st_int_wait) begin
        if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;
        else state <= fdc_cmd_pkg::st_irq;
      end
      // any status read or command write drops irq
      if (regs.acc && regs.addr == fdc_cmd_pkg::reg_cmd_status) irq <= 1'b0;
      if (state == fdc_cmd_pkg::st_irq) begin
        irq   <= 1'b1; // placed after the clear so a new irq is not lost
        state <= fdc_cmd_pkg::st_idle;
      end
      if (regs.acc && regs.we) begin
        case (regs.addr)
          fdc_cmd_pkg::reg_cmd_status: begin
            cmd         <= regs.wdata;
            state       <= fdc_cmd_pkg::st_int_wait;
            delay_cnt   <= '0;
            motor_start <= wr_starts_motor;
            case (wr_op)
              fdc_cmd_pkg::op_restore: begin
                track     <= '0;
                delay_cnt <= fdc_timing_pkg::seek_delay;
              end
              fdc_cmd_pkg::op_seek: begin
                if (track != data) begin
                  track     <= data;
                  delay_cnt <= fdc_timing_pkg::seek_delay;
                end else begin
                  state <= fdc_cmd_pkg::st_irq; // already there
                end
              end
              fdc_cmd_pkg::op_step: begin
                delay_cnt <= fdc_timing_pkg::step_delay;
                if (regs.wdata[4]) track <= step_dir ? track + 8'd1 : track - 8'd1;
              end
              fdc_cmd_pkg::op_step_in: begin
                delay_cnt <= fdc_timing_pkg::step_delay;
                step_dir  <= 1'b1;
                if (regs.wdata[4]) track <= track + 8'd1; // update flag
              end
              fdc_cmd_pkg::op_step_out: begin
                delay_cnt <= fdc_timing_pkg::step_delay;
                step_dir  <= 1'b0;
                if (regs.wdata[4]) track <= track - 8'd1;
              end
              fdc_cmd_pkg::op_read_sector, fdc_cmd_pkg::op_read_address,
              fdc_cmd_pkg::op_read_track: state <= fdc_cmd_pkg::st_io_wait;
              fdc_cmd_pkg::op_write_sector, fdc_cmd_pkg::op_write_track: begin
                if (!wr_prot) state <= fdc_cmd_pkg::st_io_wait; // protected ends at once
              end
              fdc_cmd_pkg::op_force_int: begin
                force_spinup <= 1'b1;
                state <= (regs.wdata[3:0] == 4'h0) ? fdc_cmd_pkg::st_idle : fdc_cmd_pkg::st_irq;
              end
              default: state <= fdc_cmd_pkg::st_idle;
            endcase
          end
          fdc_cmd_pkg::reg_track:  track  <= regs.wdata;
          fdc_cmd_pkg::reg_sector: sector <= regs.wdata;
          default:                 data   <= regs.wdata;
        endcase
      end
    end
  end

  // status register as seen at address 0
  always_comb begin
    status                                 = 8'h00;
    status[fdc_cmd_pkg::stat_motor_on]     = motor_on;
    status[fdc_cmd_pkg::stat_write_protect] = wr_prot;
    status[fdc_cmd_pkg::stat_spin_up_done] = cur_type1 && spin_up_done;
    status[fdc_cmd_pkg::stat_track_zero]   = cur_type1 && (track == 8'd0);
    status[fdc_cmd_pkg::stat_drq_or_index] = cur_type1 ? index_pulse : io_wait;
    status[fdc_cmd_pkg::stat_busy]         = busy;
  end

  always_comb begin
    case (regs.addr)
      fdc_cmd_pkg::reg_cmd_status: regs.rdata = status;
      fdc_cmd_pkg::reg_track:      regs.rdata = track;
      fdc_cmd_pkg::reg_sector:     regs.rdata = sector;
      default:                     regs.rdata = data;
    endcase
  end

  // both drives selected maps to drive a only
  assign drv_sel_excl = (drv_sel == 2'b00) ? 2'b10 : drv_sel;

  // view for the io controller
  always_comb begin
    case (status_sel)
      3'd0:    status_byte = cmd; // raw command
      3'd1:    status_byte = track;
      3'd2:    status_byte = sector;
      3'd4:    status_byte = {4'b0000, drv_sel_excl, drv_side, io_wait};
      default: status_byte = 8'h00; // 3 and above 4 read zero
    endcase
  end

endmodule

/* rtl/fdc_top.sv */
// fdc top level joining bus slave, controller and motor model
`timescale 1ns/1ps

module fdc_top (
  input  logic       clk,
  input  logic       motor_start_or_force, // system reset, active high
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [1:0] wb_adr,
  input  logic [7:0] wb_dat_i,
  output logic [7:0] wb_dat_o,
  output logic       wb_ack,
  input  logic [1:0] drv_sel,
  input  logic       drv_side,
  input  logic       wr_prot,
  input  logic       dma_ack,
  input  logic [2:0] status_sel,
  output logic [7:0] status_byte,
  output logic       irq
);

  logic motor_start;
  logic force_spinup;
  logic motor_on;
  logic spin_up_done;
  logic index_pulse;

  fdc_reg_if regs_if ();

  fdc_wb_slave wb_slave_i (
    .clk                  (clk),
    .motor_start_or_force (motor_start_or_force),
    .wb_cyc               (wb_cyc),
    .wb_stb               (wb_stb),
    .wb_we                (wb_we),
    .wb_adr               (wb_adr),
    .wb_dat_i             (wb_dat_i),
    .wb_dat_o             (wb_dat_o),
    .wb_ack               (wb_ack),
    .regs                 (regs_if.slave)
  );

  fdc_controller controller_i (
    .clk                  (clk),
    .motor_start_or_force (motor_start_or_force),
    .regs                 (regs_if.ctrl),
    .wr_prot              (wr_prot),
    .drv_sel              (drv_sel),
    .drv_side             (drv_side),
    .dma_ack              (dma_ack),
    .status_sel           (status_sel),
    .status_byte          (status_byte),
    .irq                  (irq),
    .motor_start          (motor_start),
    .force_spinup         (force_spinup),
    .motor_on             (motor_on),
    .spin_up_done         (spin_up_done),
    .index_pulse          (index_pulse)
  );

  fdc_motor motor_i (
    .clk                  (clk),
    .motor_start_or_force (motor_start_or_force),
    .motor_start          (motor_start),
    .force_spinup         (force_spinup),
    .motor_on             (motor_on),
    .spin_up_done         (spin_up_done),
    .index_pulse          (index_pulse)
  );

endmodule

/* test/fdc_top_checker.sv */
// bound checks on the fdc wishbone handshake and irq behavior
`timescale 1ns/1ps

module fdc_top_checker (
  input logic clk,
  input logic motor_start_or_force,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic irq
);

  int assert_fails = 0; // running count of failed assertions

  // ack only inside an active bus cycle
  ack_in_cycle: assert property (
    @(posedge clk) disable iff (motor_start_or_force) wb_ack |-> (wb_cyc && wb_stb)
  ) else begin
    $error("wb_ack high outside a wishbone cycle");
    assert_fails++;
  end

  // single cycle ack, the slave never holds it
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (motor_start_or_force) wb_ack |=> !wb_ack
  ) else begin
    $error("wb_ack high for two cycles in a row");
    assert_fails++;
  end

  // no interrupt while the system is held in reset
  irq_low_in_reset: assert property (
    @(posedge clk) motor_start_or_force |-> !irq
  ) else begin
    $error("irq high during reset");
    assert_fails++;
  end

endmodule

// one checker inside every fdc_top
bind fdc_top fdc_top_checker checker_i (
  .clk                  (clk),
  .motor_start_or_force (motor_start_or_force),
  .wb_cyc               (wb_cyc),
  .wb_stb               (wb_stb),
  .wb_ack               (wb_ack),
  .irq                  (irq)
);

/* test/fdc_top_tb.sv */
// testbench for the fdc register model, table driven through the wishbone port
`timescale 1ns/1ps

module fdc_top_tb;

  localparam int seek_wait   = fdc_timing_pkg::seek_delay;
  localparam int step_wait   = fdc_timing_pkg::step_delay;
  localparam int spinup_wait = fdc_timing_pkg::motor_spinup_time;

  // one table row, field order matters for the concatenation in add_vec
  typedef struct packed {
    logic [7:0]  setup_track;
    logic [7:0]  setup_data;
    logic [7:0]  cmd;
    logic        wp;
    logic        pre_busy;    // park in io wait with a read sector first
    logic [7:0]  exp_track;
    logic        exp_irq;
    logic        exp_io;
    logic [31:0] wait_cycles; // internal delay of the command
  } test_vec_t;

  logic        clk = 1'b0;
  logic        motor_start_or_force;
  logic        wb_cyc, wb_stb, wb_we;
  logic [1:0]  wb_adr;
  logic [7:0]  wb_dat_i;
  logic [7:0]  wb_dat_o;
  logic        wb_ack;
  logic [1:0]  drv_sel;
  logic        drv_side, wr_prot, dma_ack;
  logic [2:0]  status_sel;
  logic [7:0]  status_byte;
  logic        irq;

  test_vec_t   vecs[$];
  string       names[$];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          errors = 0;
  int          failed_tests = 0;
  int unsigned seed;
  logic [31:0] rnd;

  fdc_top fdc_top_i (.*);

  always #10 clk = ~clk; // 20 ns period

  // run limit, counted from the end of reset
  always @(posedge clk) begin
    if (!motor_start_or_force) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
        $display("Something failed");
        $finish;
      end
    end
  end

  task automatic add_vec(input string name, input logic [7:0] trk, input logic [7:0] dat,
                         input logic [7:0] cmd, input logic wp, input logic pre_busy,
                         input logic [7:0] exp_trk, input logic exp_irq, input logic exp_io,
                         input logic [31:0] wait_cycles);
    names.push_back(name);
    vecs.push_back({trk, dat, cmd, wp, pre_busy, exp_trk, exp_irq, exp_io, wait_cycles});
  endtask

  task automatic report_mismatch(input string what, input logic [7:0] exp,
                                 input logic [7:0] act);
    $display("mismatch %s: expected %h, actual %h", what, exp, act);
    errors++;
  endtask

  // one wishbone classic transfer, stb dropped on the edge after ack
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    int n;
    n = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= wdat;
    @(negedge clk);
    while (!wb_ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack) begin
      $display("no wishbone ack within 8 cycles at address %0d", adr);
      errors++;
    end
    rdat = wb_dat_o; // registered with ack, stable at negedge
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] wdat);
    logic [7:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic bus_read(input logic [1:0] adr, output logic [7:0] rdat);
    bus_cycle(1'b0, adr, 8'h00, rdat);
  endtask

  // irq watch with io wait seen on status_sel 4 bit 0
  task automatic wait_irq(input int bound, output logic seen, output logic io_seen);
    int start;
    start   = cycle_cnt;
    seen    = 1'b0;
    io_seen = 1'b0;
    while (!seen && (cycle_cnt - start) <= bound) begin
      @(negedge clk);
      seen    = irq;
      io_seen = io_seen | status_byte[0];
    end
  endtask

  // repeated status reads until one bit has the wanted value
  task automatic poll_status(input int pos, input logic val, input int bound, output logic ok);
    logic [7:0] rd;
    int         start;
    start = cycle_cnt;
    ok    = 1'b0;
    while (!ok && (cycle_cnt - start) <= bound) begin
      bus_read(2'd0, rd);
      ok = (rd[pos] == val);
    end
  endtask

  task automatic check_registers();
    logic [7:0] vals[3];
    logic [7:0] rd;
    int         i;
    int         fails;
    fails = errors;
    for (i = 0; i < 3; i++) begin
      rnd     = $urandom;
      vals[i] = rnd[7:0];
      bus_write(i[1:0] + 2'd1, vals[i]); // track, sector, data
    end
    for (i = 0; i < 3; i++) begin
      bus_read(i[1:0] + 2'd1, rd);
      if (rd != vals[i]) report_mismatch($sformatf("registers addr %0d", i + 1), vals[i], rd);
    end
    for (i = 0; i < 2; i++) begin
      @(posedge clk);
      status_sel <= i[2:0] + 3'd1;
      @(negedge clk);
      if (status_byte != vals[i])
        report_mismatch($sformatf("registers status_sel %0d", i + 1), vals[i], status_byte);
    end
    @(posedge clk);
    status_sel <= 3'd4;
    drv_sel    <= 2'b00; // both off reads as drive a
    drv_side   <= 1'b1;
    @(negedge clk);
    if (status_byte != 8'h0a) report_mismatch("registers drive bits", 8'h0a, status_byte);
    $display("registers %s", (errors == fails) ? "passed" : "failed");
    if (errors != fails) failed_tests++;
  endtask

  task automatic run_entry(input string name, input test_vec_t v);
    logic [7:0] rd;
    logic       seen;
    logic       io_seen;
    int         fails;
    fails = errors;
    @(posedge clk);
    wr_prot    <= v.wp;
    status_sel <= 3'd4;
    bus_write(2'd1, v.setup_track);
    bus_write(2'd3, v.setup_data);
    if (v.pre_busy) bus_write(2'd0, 8'h80);
    bus_write(2'd0, v.cmd);
    if (v.wait_cycles != 0) begin
      bus_read(2'd0, rd); // motor spinning and busy while the delay runs
      if ((rd & 8'h81) != 8'h81) report_mismatch({name, " busy status"}, 8'h81, rd & 8'h81);
    end
    if (v.exp_io) begin
      bus_read(2'd0, rd);
      if (rd[1:0] != 2'b11) report_mismatch({name, " io status"}, 8'h03, {6'd0, rd[1:0]});
      @(negedge clk);
      if (status_byte[0] != 1'b1) report_mismatch({name, " io wait port"}, 8'h01, status_byte);
      @(posedge clk);
      dma_ack <= 1'b1;
      @(posedge clk);
      dma_ack <= 1'b0;
    end
    wait_irq(v.wait_cycles + 8, seen, io_seen);
    if (seen != v.exp_irq) report_mismatch({name, " irq"}, v.exp_irq, seen);
    if (!v.exp_io && io_seen) report_mismatch({name, " io wait"}, 8'h00, 8'h01);
    bus_read(2'd0, rd); // status read drops irq
    @(negedge clk);
    if (irq) report_mismatch({name, " irq after status read"}, 8'h00, 8'h01);
    if (rd[0]) report_mismatch({name, " busy"}, 8'h00, rd[0]);
    if (!v.cmd[7] && rd[2] != (v.exp_track == 8'd0))
      report_mismatch({name, " track zero"}, v.exp_track == 8'd0, rd[2]);
    bus_read(2'd1, rd);
    if (rd != v.exp_track) report_mismatch({name, " track"}, v.exp_track, rd);
    $display("%s %s", name, (errors == fails) ? "passed" : "failed");
    if (errors != fails) failed_tests++;
  endtask

  task automatic check_spinup();
    logic ok;
    int   fails;
    fails = errors;
    poll_status(7, 1'b0, spinup_wait + 8, ok); // start from a stopped motor
    if (!ok) begin
      $display("spinup: motor did not stop within %0d cycles", spinup_wait + 8);
      errors++;
    end
    bus_write(2'd0, 8'h00);
    poll_status(5, 1'b1, spinup_wait, ok);
    if (!ok) begin
      $display("spinup: spin up done not reported within %0d cycles", spinup_wait);
      errors++;
    end
    poll_status(0, 1'b0, seek_wait + 8, ok);
    if (!ok) begin
      $display("spinup: restore still busy after %0d cycles", seek_wait + 8);
      errors++;
    end
    $display("spinup %s", (errors == fails) ? "passed" : "failed");
    if (errors != fails) failed_tests++;
  endtask

  initial begin
    seed = 32'h6aba_6ccc;
    rnd  = $urandom(seed);
    motor_start_or_force = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 2'd0;
    wb_dat_i   = 8'h00;
    drv_sel    = 2'b01;
    drv_side   = 1'b0;
    wr_prot    = 1'b0;
    dma_ack    = 1'b0;
    status_sel = 3'd0;
    //      name             trk    data   cmd    wp busy exp    irq io wait
    add_vec("restore",       8'h35, 8'h00, 8'h00, 0, 0, 8'h00, 1, 0, seek_wait);
    add_vec("seek",          8'h00, 8'h4a, 8'h10, 0, 0, 8'h4a, 1, 0, seek_wait);
    add_vec("seek_same",     8'h4a, 8'h4a, 8'h10, 0, 0, 8'h4a, 1, 0, 0);
    add_vec("step_in_wrap",  8'hff, 8'h00, 8'h50, 0, 0, 8'h00, 1, 0, step_wait);
    add_vec("step_again_in", 8'h10, 8'h00, 8'h30, 0, 0, 8'h11, 1, 0, step_wait);
    add_vec("step_out_wrap", 8'h00, 8'h00, 8'h70, 0, 0, 8'hff, 1, 0, step_wait);
    add_vec("step_again_out", 8'h20, 8'h00, 8'h30, 0, 0, 8'h1f, 1, 0, step_wait);
    add_vec("step_in_no_upd", 8'h20, 8'h00, 8'h40, 0, 0, 8'h20, 1, 0, step_wait);
    add_vec("read_sector",   8'h05, 8'h00, 8'h80, 0, 0, 8'h05, 1, 1, 0);
    add_vec("write_protect", 8'h05, 8'h00, 8'ha0, 1, 0, 8'h05, 1, 0, 0);
    add_vec("force_d0",      8'h07, 8'h00, 8'hd0, 0, 1, 8'h07, 0, 0, 0);
    add_vec("force_d8",      8'h07, 8'h00, 8'hd8, 0, 1, 8'h07, 1, 0, 0);
    // table delays plus 200 per row, the two extra tests get three rows and their waits
    cycle_limit = 200 * (vecs.size() + 3) + spinup_wait + seek_wait;
    foreach (vecs[k]) cycle_limit += vecs[k].wait_cycles;
    repeat (10) @(posedge clk);
    motor_start_or_force <= 1'b0;
    check_registers();
    foreach (vecs[k]) run_entry(names[k], vecs[k]);
    check_spinup();
    errors += fdc_top_i.checker_i.assert_fails; // bound assertion failures
    $display("tests %0d, failed %0d, errors %0d", vecs.size() + 2, failed_tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* fdc_top.f */
rtl/fdc_cmd_pkg.sv
rtl/fdc_timing_pkg.sv
rtl/fdc_reg_if.sv
rtl/fdc_wb_slave.sv
rtl/fdc_motor.sv
rtl/fdc_controller.sv
rtl/fdc_top.sv
test/fdc_top_checker.sv
test/fdc_top_tb.sv
